/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
SIMFLAGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Verification failed
PASS_MSG  ?= Verification passed

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  build  compile the testbench with Verilator"
	@echo "  test   build, run and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

test: build
	-$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: no result in $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* filelist.f */
+incdir+src
src/fetch_pkg.sv
src/pc_gen.sv
src/fetch_ctrl.sv
src/rd_arbiter.sv
src/axi_rd_master.sv
src/fetch_top.sv
tb/axi_mem_model.sv
tb/fetch_assert.sv
tb/tb_fetch_top.sv

/* src/axi_rd_master.sv */
`default_nettype none
`timescale 1ns/1ns

`include "fetch_defs.svh"

module axi_rd_master (
  input  wire logic               clk,
  input  wire logic               rst_n,
  // request side from the arbiter
  input  wire logic               req_valid_i,
  input  wire fetch_pkg::rd_req_t req_i,
  output logic                    req_ready_o,
  // ar channel
  output logic                    ar_valid_o,
  output fetch_pkg::rd_req_t      ar_o,
  input  wire logic               ar_ready_i,
  // r channel, single beat
  input  wire logic               r_valid_i,
  input  wire fetch_pkg::rd_rsp_t r_i,
  output logic                    r_ready_o,
  // registered response back
  output logic                    rsp_valid_o,
  output fetch_pkg::rd_rsp_t      rsp_o,
  output logic                    resp_err_o
);

  import fetch_pkg::*;

  typedef enum logic [1:0] {IDLE, ADDR, DATA} state_e;

  state_e          state_q;
  rd_req_t         ar_q;
  rd_rsp_t         rsp_q;
  logic            rsp_valid_q;
  logic            resp_err_q;
  logic [`ID_W-1:0] beat_id;
  logic            beat_bad;

  assign beat_id = r_i.id;
  // slave error or a beat tagged for another read
  assign beat_bad = (r_i.resp != 2'b00) || (beat_id != ar_q.id);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= IDLE;
      rsp_valid_q <= 1'b0;
      resp_err_q  <= 1'b0;
    end else begin
      // response flags are one cycle wide
      rsp_valid_q <= 1'b0;
      resp_err_q  <= 1'b0;
      case (state_q)
        IDLE: begin
          if (req_valid_i) state_q <= ADDR;
        end
        ADDR: begin
          if (ar_ready_i) state_q <= DATA;
        end
        DATA: begin
          if (r_valid_i) begin
            state_q     <= IDLE;
            rsp_valid_q <= 1'b1;
            resp_err_q  <= beat_bad;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // ar payload frozen until the address handshake
  always_ff @(posedge clk) begin
    if (state_q == IDLE && req_valid_i) ar_q <= req_i;
    if (state_q == DATA && r_valid_i) rsp_q <= r_i;
  end

  assign req_ready_o = (state_q == IDLE);
  assign ar_valid_o  = (state_q == ADDR);
  assign ar_o        = ar_q;
  // r always taken once the address is out
  assign r_ready_o   = (state_q == DATA);
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;
  assign resp_err_o  = resp_err_q;

endmodule

`default_nettype wire

/* src/fetch_ctrl.sv */
`default_nettype none
`timescale 1ns/1ns

`include "fetch_defs.svh"

module fetch_ctrl (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic [`XLEN-1:0]     pc_i,
  input  wire logic                 stall_i,
  input  wire logic                 redirect_i,
  output logic                      req_o,
  output fetch_pkg::rd_req_t        req_o_data,
  input  wire logic                 gnt_i,
  input  wire logic                 rsp_valid_i,
  input  wire fetch_pkg::rd_rsp_t   rsp_i,
  output logic                      advance_o,
  output logic      [`INST_W-1:0]   inst_o,
  output logic      [`XLEN-1:0]     inst_pc_o,
  output logic                      inst_valid_o
);

  import fetch_pkg::*;

  typedef enum logic [1:0] {IDLE, WAIT_GNT, WAIT_RSP} state_e;

  state_e             state_q;
  // set when the fetch in flight is stale
  logic               flush_q;
  // advance owed while stall was high
  logic               adv_pend_q;
  logic               inst_valid_q;
  logic [`INST_W-1:0] inst_q;
  logic [`XLEN-1:0]   req_pc_q;
  logic [`XLEN-1:0]   inst_pc_q;
  logic               start;
  logic               rsp_keep;
  logic               adv_req;

  // no launch on redirect or while pc still owes a step
  assign start = (state_q == IDLE) && !stall_i && !redirect_i && !adv_pend_q;
  // late redirect in the response cycle also kills it
  assign rsp_keep = (state_q == WAIT_RSP) && rsp_valid_i && !flush_q && !redirect_i;
  assign adv_req = rsp_keep || adv_pend_q;
  // pc frozen during stall
  assign advance_o = adv_req && !stall_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      flush_q      <= 1'b0;
      adv_pend_q   <= 1'b0;
      inst_valid_q <= 1'b0;
    end else begin
      inst_valid_q <= rsp_keep;
      // redirect reloads pc so the owed step is dropped
      adv_pend_q   <= adv_req && stall_i && !redirect_i;
      case (state_q)
        IDLE: begin
          if (start) begin
            state_q <= WAIT_GNT;
            flush_q <= 1'b0;
          end
        end
        WAIT_GNT: begin
          // request stays up until granted, even if stale
          if (redirect_i) flush_q <= 1'b1;
          if (gnt_i) state_q <= WAIT_RSP;
        end
        WAIT_RSP: begin
          if (redirect_i) flush_q <= 1'b1;
          if (rsp_valid_i) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // fetch address and delivered word
  always_ff @(posedge clk) begin
    if (start) req_pc_q <= pc_i;
    if (rsp_keep) begin
      inst_q    <= rsp_i.data[`INST_W-1:0];
      inst_pc_q <= req_pc_q;
    end
  end

  assign req_o           = (state_q == WAIT_GNT);
  assign req_o_data.addr = req_pc_q;
  assign req_o_data.id   = `ID_FETCH;

  // bubble shows as nop
  assign inst_o       = inst_valid_q ? inst_q : `NOP_INST;
  assign inst_pc_o    = inst_pc_q;
  assign inst_valid_o = inst_valid_q;

endmodule

`default_nettype wire

/* src/fetch_defs.svh */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// address and data width
`define XLEN 64
// one fetched instruction
`define INST_W 32
// axi id width
`define ID_W 4

// first fetch address after reset
`define RESET_PC 64'h0000_0000_8000_0000
// addi x0,x0,0
`define NOP_INST 32'h0000_0013

// id tags per requester
`define ID_FETCH 4'd1
`define ID_MEM 4'd2

`endif

/* src/fetch_pkg.sv */
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

  // macro widths as typed constants
  localparam int unsigned XLEN = `XLEN;
  localparam logic [XLEN-1:0] RESET_PC = `RESET_PC;

  // one read request toward the bus
  typedef struct packed {
    logic [`XLEN-1:0] addr;
    logic [`ID_W-1:0] id;
  } rd_req_t;

  // one read response from the bus
  typedef struct packed {
    logic [`XLEN-1:0] data;
    // axi resp code, 2'b00 is okay
    logic [1:0]       resp;
    logic [`ID_W-1:0] id;
  } rd_rsp_t;

  // who owns the current arbitration slot
  typedef enum logic {
    REQ_FETCH = 1'b0,
    REQ_MEM   = 1'b1
  } requester_e;

endpackage

`default_nettype wire

/* src/fetch_top.sv */
`default_nettype none
`timescale 1ns/1ns

`include "fetch_defs.svh"

module fetch_top (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               stall_i,
  input  wire logic               redirect_i,
  input  wire logic [`XLEN-1:0]   redirect_pc_i,
  input  wire logic               mem_req_i,
  input  wire logic [`XLEN-1:0]   mem_addr_i,
  output logic                    mem_gnt_o,
  output logic                    mem_done_o,
  output logic      [`XLEN-1:0]   mem_rdata_o,
  output logic      [`INST_W-1:0] inst_o,
  output logic      [`XLEN-1:0]   inst_pc_o,
  output logic                    inst_valid_o,
  output logic                    resp_err_o,
  output logic                    ar_valid_o,
  output fetch_pkg::rd_req_t      ar_o,
  input  wire logic               ar_ready_i,
  input  wire logic               r_valid_i,
  input  wire fetch_pkg::rd_rsp_t r_i,
  output logic                    r_ready_o
);

  import fetch_pkg::*;

  logic [`XLEN-1:0] pc;
  logic             advance;
  // fetch request path
  logic             fetch_req;
  rd_req_t          fetch_req_data;
  logic             fetch_gnt;
  logic             fetch_rsp_valid;
  // arbiter to master
  logic             arb_req_valid;
  rd_req_t          arb_req;
  logic             arb_req_ready;
  // shared response
  logic             rsp_valid;
  rd_rsp_t          rsp;

  pc_gen u_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .advance_i     (advance),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .pc_o          (pc)
  );

  fetch_ctrl u_fetch_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_i         (pc),
    .stall_i      (stall_i),
    .redirect_i   (redirect_i),
    .req_o        (fetch_req),
    .req_o_data   (fetch_req_data),
    .gnt_i        (fetch_gnt),
    .rsp_valid_i  (fetch_rsp_valid),
    .rsp_i        (rsp),
    .advance_o    (advance),
    .inst_o       (inst_o),
    .inst_pc_o    (inst_pc_o),
    .inst_valid_o (inst_valid_o)
  );

  rd_arbiter u_rd_arbiter (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_req_i       (fetch_req),
    .fetch_req_data_i  (fetch_req_data),
    .fetch_gnt_o       (fetch_gnt),
    .mem_req_i         (mem_req_i),
    .mem_addr_i        (mem_addr_i),
    .mem_gnt_o         (mem_gnt_o),
    .req_valid_o       (arb_req_valid),
    .req_o             (arb_req),
    .req_ready_i       (arb_req_ready),
    .rsp_valid_i       (rsp_valid),
    .rsp_i             (rsp),
    .fetch_rsp_valid_o (fetch_rsp_valid),
    .mem_done_o        (mem_done_o),
    .mem_rdata_o       (mem_rdata_o)
  );

  axi_rd_master u_axi_rd_master (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (arb_req_valid),
    .req_i       (arb_req),
    .req_ready_o (arb_req_ready),
    .ar_valid_o  (ar_valid_o),
    .ar_o        (ar_o),
    .ar_ready_i  (ar_ready_i),
    .r_valid_i   (r_valid_i),
    .r_i         (r_i),
    .r_ready_o   (r_ready_o),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .resp_err_o  (resp_err_o)
  );

endmodule

`default_nettype wire

/* src/pc_gen.sv */
`default_nettype none
`timescale 1ns/1ns

module pc_gen (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  // step to next sequential instruction
  input  wire logic                       advance_i,
  // branch or jalr target from decode
  input  wire logic                       redirect_i,
  input  wire logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
  output logic      [fetch_pkg::XLEN-1:0] pc_o
);

  import fetch_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_seq;

  // no prediction, fall through only
  assign pc_seq = pc_q + XLEN'(4);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else if (redirect_i) begin
      // redirect beats a pending advance
      pc_q <= redirect_pc_i;
    end else if (advance_i) begin
      pc_q <= pc_seq;
    end
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

/* src/rd_arbiter.sv */
`default_nettype none
`timescale 1ns/1ns

`include "fetch_defs.svh"

module rd_arbiter (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               fetch_req_i,
  input  wire fetch_pkg::rd_req_t fetch_req_data_i,
  output logic                    fetch_gnt_o,
  input  wire logic               mem_req_i,
  input  wire logic [`XLEN-1:0]   mem_addr_i,
  output logic                    mem_gnt_o,
  output logic                    req_valid_o,
  output fetch_pkg::rd_req_t      req_o,
  input  wire logic               req_ready_i,
  input  wire logic               rsp_valid_i,
  input  wire fetch_pkg::rd_rsp_t rsp_i,
  output logic                    fetch_rsp_valid_o,
  output logic                    mem_done_o,
  output logic      [`XLEN-1:0]   mem_rdata_o
);

  import fetch_pkg::*;

  requester_e pick;
  // one read outstanding at most
  logic       busy_q;
  logic       xfer;

  // memory stage always first
  assign pick = mem_req_i ? REQ_MEM : REQ_FETCH;

  assign req_valid_o = !busy_q && (mem_req_i || fetch_req_i);
  assign req_o.addr  = (pick == REQ_MEM) ? mem_addr_i : fetch_req_data_i.addr;
  assign req_o.id    = (pick == REQ_MEM) ? `ID_MEM : fetch_req_data_i.id;
  assign xfer        = req_valid_o && req_ready_i;

  // grant is the transfer cycle
  assign mem_gnt_o   = xfer && (pick == REQ_MEM);
  assign fetch_gnt_o = xfer && (pick == REQ_FETCH);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (xfer) begin
      busy_q <= 1'b1;
    end else if (rsp_valid_i) begin
      busy_q <= 1'b0;
    end
  end

  // steer by id tag
  assign fetch_rsp_valid_o = rsp_valid_i && (rsp_i.id == `ID_FETCH);
  assign mem_done_o        = rsp_valid_i && (rsp_i.id == `ID_MEM);
  assign mem_rdata_o       = rsp_i.data;

endmodule

`default_nettype wire

/* tb/axi_mem_model.sv */
`default_nettype none
`timescale 1ns/1ns

module axi_mem_model (
  input  wire logic               clk,
  input  wire logic               rst_n,
  // ar channel from the master
  input  wire logic               ar_valid_i,
  input  wire fetch_pkg::rd_req_t ar_i,
  output logic                    ar_ready_o,
  // r channel back to the master
  output logic                    r_valid_o,
  output fetch_pkg::rd_rsp_t      r_o,
  input  wire logic               r_ready_i
);

  import fetch_pkg::*;

  // every word is its own address scrambled
  localparam logic [63:0] PATTERN = 64'h5A5A_5A5A_5A5A_5A5A;

  logic       busy_q;
  logic [1:0] delay_q;
  rd_req_t    req_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      r_o        <= '0;
      busy_q     <= 1'b0;
      delay_q    <= '0;
      req_q      <= '0;
    end else if (!busy_q) begin
      if (ar_valid_i && ar_ready_o) begin
        busy_q     <= 1'b1;
        req_q      <= ar_i;
        ar_ready_o <= 1'b0;
        // 0 to 3 extra cycles before the beat
        delay_q    <= 2'($urandom_range(0, 3));
      end else begin
        // ready drops about one cycle in four
        ar_ready_o <= ($urandom_range(0, 3) != 0);
      end
    end else if (!r_valid_o) begin
      if (delay_q == 2'd0) begin
        r_valid_o <= 1'b1;
        r_o.data  <= req_q.addr ^ PATTERN;
        r_o.resp  <= 2'b00;
        r_o.id    <= req_q.id;
      end else begin
        delay_q <= delay_q - 2'd1;
      end
    end else if (r_ready_i) begin
      // single beat, done
      r_valid_o <= 1'b0;
      busy_q    <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* tb/fetch_assert.sv */
`default_nettype none
`timescale 1ns/1ns

`include "fetch_defs.svh"

module fetch_assert (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               stall_i,
  input  wire logic               redirect_i,
  input  wire logic [`XLEN-1:0]   redirect_pc_i,
  input  wire logic               mem_req_i,
  input  wire logic [`XLEN-1:0]   mem_addr_i,
  input  wire logic               mem_gnt_o,
  input  wire logic               mem_done_o,
  input  wire logic [`XLEN-1:0]   mem_rdata_o,
  input  wire logic [`INST_W-1:0] inst_o,
  input  wire logic [`XLEN-1:0]   inst_pc_o,
  input  wire logic               inst_valid_o,
  input  wire logic               resp_err_o,
  input  wire logic               ar_valid_o,
  input  wire fetch_pkg::rd_req_t ar_o,
  input  wire logic               ar_ready_i,
  input  wire logic               r_valid_i,
  input  wire logic               r_ready_o,
  // internal fetch request and grant
  input  wire logic               fetch_req_i,
  input  wire logic               fetch_gnt_i
);

  import fetch_pkg::*;

  localparam logic [`XLEN-1:0] PATTERN = 64'h5A5A_5A5A_5A5A_5A5A;

  // bumped by every failing assertion, read by the testbench
  int unsigned fail_cnt = 0;

  logic [`XLEN-1:0] exp_pc_q;
  logic [`XLEN-1:0] mem_addr_q;
  logic [`ID_W-1:0] exp_ar_id_q;
  // a read address went out, data not back yet
  logic             out_q;
  // events seen since stall rose
  int unsigned      stall_ar_q;
  int unsigned      stall_inst_q;
  logic             ar_hs;
  logic             r_hs;
  logic             fetch_ar_hs;

  assign ar_hs       = ar_valid_o && ar_ready_i;
  assign r_hs        = r_valid_i && r_ready_o;
  assign fetch_ar_hs = ar_hs && (ar_o.id == `ID_FETCH);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_pc_q     <= `RESET_PC;
      mem_addr_q   <= '0;
      exp_ar_id_q  <= '0;
      out_q        <= 1'b0;
      stall_ar_q   <= 0;
      stall_inst_q <= 0;
    end else begin
      // redirect target wins over sequential step
      if (redirect_i) exp_pc_q <= redirect_pc_i;
      else if (inst_valid_o) exp_pc_q <= inst_pc_o + 64'd4;
      if (mem_gnt_o) mem_addr_q <= mem_addr_i;
      // id the next ar must carry
      if (mem_gnt_o) exp_ar_id_q <= `ID_MEM;
      else if (fetch_gnt_i) exp_ar_id_q <= `ID_FETCH;
      if (ar_hs) out_q <= 1'b1;
      else if (r_hs) out_q <= 1'b0;
      if (!stall_i) begin
        stall_ar_q   <= 0;
        stall_inst_q <= 0;
      end else begin
        if (fetch_ar_hs) stall_ar_q <= stall_ar_q + 1;
        if (inst_valid_o) stall_inst_q <= stall_inst_q + 1;
      end
    end
  end

  a_inst_data: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_o |-> inst_o == (inst_pc_o[31:0] ^ PATTERN[31:0]))
    else begin
      fail_cnt++;
      $error("Mismatch inst_o got %h expected %h", $sampled(inst_o),
             $sampled(inst_pc_o[31:0]) ^ PATTERN[31:0]);
    end

  a_bubble_nop: assert property (@(posedge clk) disable iff (!rst_n)
    !inst_valid_o |-> inst_o == `NOP_INST)
    else begin
      fail_cnt++;
      $error("Mismatch inst_o got %h expected %h", $sampled(inst_o), `NOP_INST);
    end

  // sequence after reset and after every redirect
  a_pc_order: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_o |-> inst_pc_o == exp_pc_q)
    else begin
      fail_cnt++;
      $error("Mismatch inst_pc_o got %h expected %h", $sampled(inst_pc_o), $sampled(exp_pc_q));
    end

  a_stall_ar: assert property (@(posedge clk) disable iff (!rst_n)
    (stall_i && fetch_ar_hs) |-> stall_ar_q == 0)
    else begin
      fail_cnt++;
      $error("A new fetch address went out while stall was high");
    end

  // fetch launch only from a cycle with stall low
  a_stall_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(fetch_req_i) |-> !$past(stall_i))
    else begin
      fail_cnt++;
      $error("A new fetch request was raised while stall was high");
    end

  a_stall_inst: assert property (@(posedge clk) disable iff (!rst_n)
    (stall_i && inst_valid_o) |-> stall_inst_q == 0)
    else begin
      fail_cnt++;
      $error("More than one instruction arrived after stall rose");
    end

  a_mem_first: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req_i && fetch_req_i && (mem_gnt_o || fetch_gnt_i)) |-> mem_gnt_o)
    else begin
      fail_cnt++;
      $error("Fetch won arbitration over a pending memory read");
    end

  a_ar_id: assert property (@(posedge clk) disable iff (!rst_n)
    ar_hs |-> ar_o.id == exp_ar_id_q)
    else begin
      fail_cnt++;
      $error("Mismatch ar_o.id got %h expected %h", $sampled(ar_o.id), $sampled(exp_ar_id_q));
    end

  a_mem_data: assert property (@(posedge clk) disable iff (!rst_n)
    mem_done_o |-> mem_rdata_o == (mem_addr_q ^ PATTERN))
    else begin
      fail_cnt++;
      $error("Mismatch mem_rdata_o got %h expected %h", $sampled(mem_rdata_o),
             $sampled(mem_addr_q) ^ PATTERN);
    end

  // memory model always answers okay with the id it was given
  a_no_err: assert property (@(posedge clk) disable iff (!rst_n)
    !resp_err_o)
    else begin
      fail_cnt++;
      $error("Mismatch resp_err_o got %h expected %h", $sampled(resp_err_o), 1'b0);
    end

  a_one_out: assert property (@(posedge clk) disable iff (!rst_n)
    ar_hs |-> !out_q)
    else begin
      fail_cnt++;
      $error("A second read address went out while a read was outstanding");
    end

  a_r_owed: assert property (@(posedge clk) disable iff (!rst_n)
    r_hs |-> out_q)
    else begin
      fail_cnt++;
      $error("Read data was accepted with no read outstanding");
    end

  // valid and payload hold under back-pressure
  a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
    $past(ar_valid_o && !ar_ready_i) |-> (ar_valid_o && ar_o == $past(ar_o)))
    else begin
      fail_cnt++;
      $error("AR channel changed while ar_ready_i was low");
    end

  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> (!ar_valid_o && !r_ready_o && !inst_valid_o && !mem_done_o
                && inst_o == `NOP_INST))
    else begin
      fail_cnt++;
      $error("Control outputs were active during reset");
    end

endmodule

bind fetch_top fetch_assert u_fetch_assert (
  .clk           (clk),
  .rst_n         (rst_n),
  .stall_i       (stall_i),
  .redirect_i    (redirect_i),
  .redirect_pc_i (redirect_pc_i),
  .mem_req_i     (mem_req_i),
  .mem_addr_i    (mem_addr_i),
  .mem_gnt_o     (mem_gnt_o),
  .mem_done_o    (mem_done_o),
  .mem_rdata_o   (mem_rdata_o),
  .inst_o        (inst_o),
  .inst_pc_o     (inst_pc_o),
  .inst_valid_o  (inst_valid_o),
  .resp_err_o    (resp_err_o),
  .ar_valid_o    (ar_valid_o),
  .ar_o          (ar_o),
  .ar_ready_i    (ar_ready_i),
  .r_valid_i     (r_valid_i),
  .r_ready_o     (r_ready_o),
  .fetch_req_i   (fetch_req),
  .fetch_gnt_i   (fetch_gnt)
);

`default_nettype wire

/* tb/tb_fetch_top.sv */
`default_nettype none
`timescale 1ns/1ns

`include "fetch_defs.svh"

module tb_fetch_top;

  import fetch_pkg::*;

  localparam int unsigned WAIT_LIMIT  = 400;
  localparam int unsigned SEED        = 50948;
  // events a wait can look for
  localparam int unsigned EV_MEM_GNT  = 0;
  localparam int unsigned EV_MEM_DONE = 1;
  localparam int unsigned EV_FETCH_AR = 2;

  logic               clk;
  logic               rst_n;
  logic               stall_i;
  logic               redirect_i;
  logic [`XLEN-1:0]   redirect_pc_i;
  logic               mem_req_i;
  logic [`XLEN-1:0]   mem_addr_i;
  logic               mem_gnt_o;
  logic               mem_done_o;
  logic [`XLEN-1:0]   mem_rdata_o;
  logic [`INST_W-1:0] inst_o;
  logic [`XLEN-1:0]   inst_pc_o;
  logic               inst_valid_o;
  logic               resp_err_o;
  logic               ar_valid_o;
  rd_req_t            ar_o;
  logic               ar_ready_i;
  logic               r_valid_i;
  rd_rsp_t            r_i;
  logic               r_ready_o;
  int unsigned        timeout_cnt;
  int unsigned        assert_fails;

  fetch_top dut (.*);

  axi_mem_model u_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid_o),
    .ar_i       (ar_o),
    .ar_ready_o (ar_ready_i),
    .r_valid_o  (r_valid_i),
    .r_o        (r_i),
    .r_ready_i  (r_ready_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // drive point just after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) tick();
  endtask

  function automatic logic event_seen(input int unsigned kind);
    case (kind)
      EV_MEM_GNT:  return mem_gnt_o;
      EV_MEM_DONE: return mem_done_o;
      EV_FETCH_AR: return ar_valid_o && ar_ready_i && (ar_o.id == `ID_FETCH);
      default:     return 1'b0;
    endcase
  endfunction

  // sampled mid-cycle, returns at the negedge where it was seen
  task automatic wait_for(input int unsigned kind, input string what);
    int unsigned cyc;
    logic        hit;
    cyc = 0;
    hit = 1'b0;
    while (!hit && cyc < WAIT_LIMIT) begin
      @(negedge clk);
      hit = event_seen(kind);
      cyc++;
    end
    if (!hit) begin
      timeout_cnt++;
      $display("Timeout: no %s within %0d cycles", what, WAIT_LIMIT);
    end
  endtask

  // count inst_valid_o pulses, then realign to the drive point
  task automatic wait_insts(input int unsigned n);
    int unsigned got;
    int unsigned cyc;
    got = 0;
    cyc = 0;
    while (got < n && cyc < WAIT_LIMIT) begin
      @(negedge clk);
      if (inst_valid_o) got++;
      cyc++;
    end
    if (got < n) begin
      timeout_cnt++;
      $display("Timeout: only %0d of %0d instructions arrived", got, n);
    end
    tick();
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n         = 1'b0;
    stall_i       = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    mem_req_i     = 1'b0;
    mem_addr_i    = '0;
    timeout_cnt   = 0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // free running fetch from the reset pc
    wait_insts(8);

    // stalls of random length and offset
    for (int i = 0; i < 6; i++) begin
      idle_cycles($urandom_range(0, 3));
      stall_i = 1'b1;
      idle_cycles($urandom_range(2, 8));
      stall_i = 1'b0;
      wait_insts(2);
    end

    // even passes hit a fetch that is already on the bus
    for (int i = 0; i < 6; i++) begin
      if (i % 2 == 0) begin
        wait_for(EV_FETCH_AR, "fetch address handshake");
        tick();
      end else begin
        idle_cycles($urandom_range(0, 5));
      end
      redirect_i    = 1'b1;
      redirect_pc_i = 64'h0000_0000_8000_4000 + 64'(i) * 64'h140;
      tick();
      redirect_i = 1'b0;
      wait_insts(3);
    end

    // memory stage reads racing the fetch stream
    for (int b = 0; b < 5; b++) begin
      for (int k = 0; k < 3; k++) begin
        mem_addr_i = {$urandom(), $urandom()} & 64'hFFFF_FFFF_FFFF_FFF8;
        mem_req_i  = 1'b1;
        wait_for(EV_MEM_GNT, "memory grant");
        tick();
        mem_req_i = 1'b0;
        wait_for(EV_MEM_DONE, "memory read data");
        tick();
      end
      wait_insts(2);
    end

    idle_cycles(4);
    assert_fails = dut.u_fetch_assert.fail_cnt;
    $display("Run complete: %0d assertion failures, %0d timeouts", assert_fails, timeout_cnt);
    if (assert_fails == 0 && timeout_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
